// File: Makefile
# Verilator build and run of the rename stage testbench.

VERILATOR ?= verilator
TOP       ?= rename_tb
FILELIST  ?= rename_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Result: PASSED

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

$(SIM): $(FILELIST) $(SRCS) rtl/rename_defines.svh verif/rename_vectors.txt
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: rename_top.f
+incdir+rtl
rtl/rename_pkg.sv
rtl/inst_decode.sv
rtl/regfile.sv
rtl/rob_tags.sv
rtl/dispatch_ctrl.sv
rtl/rename_top.sv
verif/rename_tb.sv

// File: rtl/dispatch_ctrl.sv
`timescale 1ns/1ps
`include "rename_defines.svh"

module dispatch_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy,
    input  logic               clr,
    input  logic               inst_valid,

    input  rename_pkg::op_e    op,
    input  logic               writes_rd,
    input  logic               full,

    input  logic [`REG_W-1:0]  rd,
    input  logic [`XLEN-1:0]   imm,
    input  logic [`XLEN-1:0]   pc,
    input  logic [`TAG_W-1:0]  alloc_tag,
    input  logic [`XLEN-1:0]   rs1_val,
    input  logic [`TAG_W-1:0]  rs1_tag,
    input  logic [`XLEN-1:0]   rs2_val,
    input  logic [`TAG_W-1:0]  rs2_tag,

    output logic               accept,
    output logic               claim,
    output logic               stall,

    output logic               disp_en,
    output rename_pkg::op_e    disp_op,
    output logic [`REG_W-1:0]  disp_rd,
    output logic [`XLEN-1:0]   disp_imm,
    output logic [`XLEN-1:0]   disp_pc,
    output logic [`TAG_W-1:0]  disp_tag,
    output logic [`XLEN-1:0]   disp_rs1_val,
    output logic [`TAG_W-1:0]  disp_rs1_tag,
    output logic [`XLEN-1:0]   disp_rs2_val,
    output logic [`TAG_W-1:0]  disp_rs2_tag
);
    import rename_pkg::*;

    assign accept = rdy && !clr && inst_valid && (op != ILLEGAL) && (!writes_rd || !full);
    assign stall  = inst_valid && writes_rd && full;  // source holds inst.
    assign claim  = accept && writes_rd;

    // operands come from the state before this edge.
    always_ff @(posedge clk) begin
        if (rst || !accept) begin
            disp_en      <= 1'b0;
            disp_op      <= op_e'(0);
            disp_rd      <= '0;
            disp_imm     <= '0;
            disp_pc      <= '0;
            disp_tag     <= '0;
            disp_rs1_val <= '0;
            disp_rs1_tag <= '0;
            disp_rs2_val <= '0;
            disp_rs2_tag <= '0;
        end else begin
            disp_en      <= 1'b1;
            disp_op      <= op;
            disp_rd      <= rd;
            disp_imm     <= imm;
            disp_pc      <= pc;
            disp_tag     <= writes_rd ? alloc_tag : '0;
            disp_rs1_val <= rs1_val;
            disp_rs1_tag <= rs1_tag;
            disp_rs2_val <= rs2_val;
            disp_rs2_tag <= rs2_tag;
        end
    end

endmodule

// File: rtl/inst_decode.sv
`timescale 1ns/1ps
`include "rename_defines.svh"

module inst_decode (
    input  rename_pkg::inst_u  inst,
    output rename_pkg::op_e    op,
    output logic [`REG_W-1:0]  rs1,
    output logic [`REG_W-1:0]  rs2,
    output logic [`REG_W-1:0]  rd,
    output logic [`XLEN-1:0]   imm,
    output logic               writes_rd
);
    import rename_pkg::*;

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    logic [6:0] funct7;
    logic [2:0] funct3;
    logic       alt_ok;

    assign funct7 = inst.r.funct7;
    assign funct3 = inst.r.funct3;
    assign alt_ok = (funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101); // sub, sra.

    //////////////////////////////////////////////////
    // opcode class
    //////////////////////////////////////////////////

    always_comb begin
        case (inst.r.opcode)
            OPC_LUI:    op = LUI;
            OPC_AUIPC:  op = AUIPC;
            OPC_JAL:    op = JAL;
            OPC_JALR:   op = (funct3 == 3'b000) ? JALR : ILLEGAL;
            OPC_BRANCH: op = (funct3 == 3'b010 || funct3 == 3'b011) ? ILLEGAL : BRANCH;
            OPC_LOAD:   op = (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) ? LOAD : ILLEGAL;
            OPC_STORE:  op = (funct3 inside {3'b000, 3'b001, 3'b010}) ? STORE : ILLEGAL;
            OPC_OP:     op = (funct7 == 7'b0 || alt_ok) ? ALU_R : ILLEGAL; // M ext drops here.
            OPC_OP_IMM: begin
                if (funct3 == 3'b001)
                    op = (funct7 == 7'b0) ? ALU_I : ILLEGAL;
                else if (funct3 == 3'b101)
                    op = (funct7 == 7'b0 || funct7 == 7'b0100000) ? ALU_I : ILLEGAL;
                else
                    op = ALU_I;
            end
            default:    op = ILLEGAL;
        endcase
    end

    //////////////////////////////////////////////////
    // fields and immediates
    //////////////////////////////////////////////////

    always_comb begin
        rs1 = inst.r.rs1;
        rs2 = '0;
        rd  = inst.r.rd;
        imm = '0;
        case (op)
            ALU_R: rs2 = inst.r.rs2;
            ALU_I, LOAD, JALR: imm = {{20{funct7[6]}}, funct7, inst.r.rs2};
            STORE: begin
                rs1 = inst.s.rs1;
                rs2 = inst.s.rs2;
                rd  = '0;
                imm = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
            end
            BRANCH: begin
                rs1 = inst.s.rs1;
                rs2 = inst.s.rs2;
                rd  = '0;
                imm = {{19{inst.s.imm_hi[6]}}, inst.s.imm_hi[6], inst.s.imm_lo[0],
                       inst.s.imm_hi[5:0], inst.s.imm_lo[4:1], 1'b0};
            end
            LUI, AUIPC: begin
                rs1 = '0;
                imm = {funct7, inst.r.rs2, inst.r.rs1, funct3, 12'b0};
            end
            JAL: begin
                rs1 = '0;
                imm = {{11{funct7[6]}}, funct7[6], inst.r.rs1, funct3, inst.r.rs2[0],
                       funct7[5:0], inst.r.rs2[4:1], 1'b0};
            end
            default: begin // illegal words carry nothing.
                rs1 = '0;
                rd  = '0;
            end
        endcase
    end

    assign writes_rd = (op != STORE) && (op != BRANCH) && (op != ILLEGAL) && (rd != '0);

endmodule

// File: rtl/regfile.sv
`timescale 1ns/1ps
`include "rename_defines.svh"

module regfile (
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy,
    input  logic               clr,

    input  logic [`REG_W-1:0]  rs1,
    input  logic [`REG_W-1:0]  rs2,
    output logic [`XLEN-1:0]   rs1_val,
    output logic [`TAG_W-1:0]  rs1_tag,
    output logic [`XLEN-1:0]   rs2_val,
    output logic [`TAG_W-1:0]  rs2_tag,

    // rename of rd on dispatch.
    input  logic               claim_en,
    input  logic [`REG_W-1:0]  claim_rd,
    input  logic [`TAG_W-1:0]  claim_tag,

    // in-order retirement.
    input  logic               commit_en,
    input  logic [`REG_W-1:0]  commit_rd,
    input  logic [`TAG_W-1:0]  commit_tag,
    input  logic [`XLEN-1:0]   commit_data
);

    logic [`XLEN-1:0]  data_q [`REG_NUM];
    logic [`TAG_W-1:0] nick_q [`REG_NUM];
    logic              commit_hit;
    logic              commit_wr;

    // only the youngest writer of a register may land its value.
    assign commit_hit = commit_en && (commit_rd != '0) && (nick_q[commit_rd] == commit_tag);

    // a clear still lets the retiring value through.
    assign commit_wr = clr ? (commit_en && (commit_rd != '0)) : (rdy && commit_hit);

    //////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (commit_wr) begin
            data_q[commit_rd] <= commit_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clr) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                nick_q[i] <= '0;
            end
        end else if (rdy) begin
            if (commit_hit) begin
                nick_q[commit_rd] <= '0;
            end
            if (claim_en && (claim_rd != '0)) begin
                nick_q[claim_rd] <= claim_tag; // claim wins over commit.
            end
        end
    end

    //////////////////////////////////////////////////
    // read ports
    //////////////////////////////////////////////////

    // x0 data is never written, so it is forced here.
    assign rs1_val = (rs1 == '0) ? '0 : data_q[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : data_q[rs2];
    assign rs1_tag = nick_q[rs1];
    assign rs2_tag = nick_q[rs2];

endmodule

// File: rtl/rename_defines.svh
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

//////////////////////////////////////////////////
// datapath
//////////////////////////////////////////////////

`define XLEN      32

// architectural registers x0..x31.
`define REG_NUM   32
`define REG_W     5

//////////////////////////////////////////////////
// rob tags
//////////////////////////////////////////////////

// tags run 1..ROB_DEPTH and tag 0 means the value is ready.
`define ROB_DEPTH 8
`define ROB_PTR_W 3
`define TAG_W     4

`endif

// File: rtl/rename_pkg.sv
package rename_pkg;

    // operation class seen by the dispatch side.
    typedef enum logic [3:0] {
        ALU_R   = 4'd0,
        ALU_I   = 4'd1,
        LOAD    = 4'd2,
        STORE   = 4'd3,
        BRANCH  = 4'd4,
        JAL     = 4'd5,
        JALR    = 4'd6,
        LUI     = 4'd7,
        AUIPC   = 4'd8,
        ILLEGAL = 4'd9
    } op_e;

    // the I, U and J forms share the field positions of the register form.
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_r_t;

    // in the store and branch form the rd bits carry the low immediate.
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } inst_s_t;

    typedef union packed {
        inst_r_t r;
        inst_s_t s;
    } inst_u;

endpackage

// File: rtl/rename_top.sv
`timescale 1ns/1ps
`include "rename_defines.svh"

module rename_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy,
    input  logic               clr,
    input  logic               inst_valid,
    input  rename_pkg::inst_u  inst,
    input  logic [`XLEN-1:0]   pc,
    input  logic               commit_en,
    input  logic [`XLEN-1:0]   commit_data,

    output logic               stall,
    output logic               disp_en,
    output rename_pkg::op_e    disp_op,
    output logic [`REG_W-1:0]  disp_rd,
    output logic [`XLEN-1:0]   disp_imm,
    output logic [`XLEN-1:0]   disp_pc,
    output logic [`TAG_W-1:0]  disp_tag,
    output logic [`XLEN-1:0]   rs1_val,
    output logic [`TAG_W-1:0]  rs1_tag,
    output logic [`XLEN-1:0]   rs2_val,
    output logic [`TAG_W-1:0]  rs2_tag
);
    import rename_pkg::*;

    op_e               dec_op;
    logic [`REG_W-1:0] dec_rs1;
    logic [`REG_W-1:0] dec_rs2;
    logic [`REG_W-1:0] dec_rd;
    logic [`XLEN-1:0]  dec_imm;
    logic              dec_writes_rd;

    logic [`XLEN-1:0]  rf_rs1_val;
    logic [`TAG_W-1:0] rf_rs1_tag;
    logic [`XLEN-1:0]  rf_rs2_val;
    logic [`TAG_W-1:0] rf_rs2_tag;

    logic              claim;
    logic              full;
    logic [`TAG_W-1:0] alloc_tag;
    logic [`TAG_W-1:0] head_tag;
    logic [`REG_W-1:0] head_rd;

    inst_decode u_decode (
        .inst      (inst),
        .op        (dec_op),
        .rs1       (dec_rs1),
        .rs2       (dec_rs2),
        .rd        (dec_rd),
        .imm       (dec_imm),
        .writes_rd (dec_writes_rd)
    );

    regfile u_regfile (
        .clk         (clk),
        .rst         (rst),
        .rdy         (rdy),
        .clr         (clr),
        .rs1         (dec_rs1),
        .rs2         (dec_rs2),
        .rs1_val     (rf_rs1_val),
        .rs1_tag     (rf_rs1_tag),
        .rs2_val     (rf_rs2_val),
        .rs2_tag     (rf_rs2_tag),
        .claim_en    (claim),
        .claim_rd    (dec_rd),
        .claim_tag   (alloc_tag),
        .commit_en   (commit_en),
        .commit_rd   (head_rd),
        .commit_tag  (head_tag),
        .commit_data (commit_data)
    );

    rob_tags u_rob_tags (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .clr       (clr),
        .alloc_en  (claim),
        .alloc_rd  (dec_rd),
        .alloc_tag (alloc_tag),
        .retire_en (commit_en),
        .head_tag  (head_tag),
        .head_rd   (head_rd),
        .full      (full)
    );

    dispatch_ctrl u_dispatch (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .clr          (clr),
        .inst_valid   (inst_valid),
        .op           (dec_op),
        .writes_rd    (dec_writes_rd),
        .full         (full),
        .rd           (dec_rd),
        .imm          (dec_imm),
        .pc           (pc),
        .alloc_tag    (alloc_tag),
        .rs1_val      (rf_rs1_val),
        .rs1_tag      (rf_rs1_tag),
        .rs2_val      (rf_rs2_val),
        .rs2_tag      (rf_rs2_tag),
        .accept       (),
        .claim        (claim),
        .stall        (stall),
        .disp_en      (disp_en),
        .disp_op      (disp_op),
        .disp_rd      (disp_rd),
        .disp_imm     (disp_imm),
        .disp_pc      (disp_pc),
        .disp_tag     (disp_tag),
        .disp_rs1_val (rs1_val),
        .disp_rs1_tag (rs1_tag),
        .disp_rs2_val (rs2_val),
        .disp_rs2_tag (rs2_tag)
    );

endmodule

// File: rtl/rob_tags.sv
`timescale 1ns/1ps
`include "rename_defines.svh"

module rob_tags (
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy,
    input  logic               clr,

    input  logic               alloc_en,
    input  logic [`REG_W-1:0]  alloc_rd,
    output logic [`TAG_W-1:0]  alloc_tag,

    input  logic               retire_en,
    output logic [`TAG_W-1:0]  head_tag,
    output logic [`REG_W-1:0]  head_rd,

    output logic               full
);

    logic [`ROB_PTR_W-1:0] head_q;
    logic [`ROB_PTR_W-1:0] tail_q;
    logic [`TAG_W-1:0]     count_q;
    logic [`REG_W-1:0]     rd_mem [`ROB_DEPTH];
    logic                  empty;
    logic                  alloc_go;
    logic                  retire_go;

    assign full  = (count_q == `ROB_DEPTH);
    assign empty = (count_q == '0);

    assign alloc_go  = rdy && !clr && alloc_en && !full;
    assign retire_go = rdy && !clr && retire_en && !empty; // commits on an empty rob are dropped.

    // tag is the entry index plus one.
    assign alloc_tag = {1'b0, tail_q} + 1'b1;
    assign head_tag  = empty ? '0 : {1'b0, head_q} + 1'b1;
    assign head_rd   = empty ? '0 : rd_mem[head_q];  // x0 when empty so nothing is written.

    always_ff @(posedge clk) begin
        if (alloc_go) begin
            rd_mem[tail_q] <= alloc_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clr) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (alloc_go) begin
                tail_q <= tail_q + 1'b1;
            end
            if (retire_go) begin
                head_q <= head_q + 1'b1;
            end
            case ({alloc_go, retire_go})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

// File: verif/rename_tb.sv
`timescale 1ns/1ps
`include "rename_defines.svh"

module rename_tb;
    import rename_pkg::*;

    localparam int NCOL       = 18;    // columns per vector line.
    localparam int ADDR_W     = 11;
    localparam int MAX_LINES  = 100;
    localparam int HALF_CLK   = 20;
    localparam int MAX_CYCLES = 400;
    localparam int SETTLE_MAX = 10;
    localparam logic [31:0] END_MARK = 32'hff;

    logic              clk;
    logic              rst;
    logic              rdy;
    logic              clr;
    logic              inst_valid;
    logic [31:0]       inst_word;
    logic [`XLEN-1:0]  pc;
    logic              commit_en;
    logic [`XLEN-1:0]  commit_data;

    logic              stall;
    logic              disp_en;
    op_e               disp_op;
    logic [`REG_W-1:0] disp_rd;
    logic [`XLEN-1:0]  disp_imm;
    logic [`XLEN-1:0]  disp_pc;
    logic [`TAG_W-1:0] disp_tag;
    logic [`XLEN-1:0]  rs1_val;
    logic [`TAG_W-1:0] rs1_tag;
    logic [`XLEN-1:0]  rs2_val;
    logic [`TAG_W-1:0] rs2_tag;

    logic [31:0] vec_mem [2**ADDR_W];
    int          errors;
    int          checks;
    int          group_errors;
    int          line_no;

    rename_top UUT (
        .clk         (clk),
        .rst         (rst),
        .rdy         (rdy),
        .clr         (clr),
        .inst_valid  (inst_valid),
        .inst        (inst_word),
        .pc          (pc),
        .commit_en   (commit_en),
        .commit_data (commit_data),
        .stall       (stall),
        .disp_en     (disp_en),
        .disp_op     (disp_op),
        .disp_rd     (disp_rd),
        .disp_imm    (disp_imm),
        .disp_pc     (disp_pc),
        .disp_tag    (disp_tag),
        .rs1_val     (rs1_val),
        .rs1_tag     (rs1_tag),
        .rs2_val     (rs2_val),
        .rs2_tag     (rs2_tag)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_CLK clk = ~clk;
    end

    // hard stop if the vector loop never gets to its end.
    initial begin
        int cycles;
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("simulation ran past %0d cycles without finishing", MAX_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] field(input int col);
        return vec_mem[ADDR_W'(line_no * NCOL + col)];
    endfunction

    function automatic string group_name(input logic [31:0] grp);
        case (grp)
            32'd1:   return "decode and immediates";
            32'd2:   return "stall on full rob";
            32'd3:   return "clear and rdy";
            32'd4:   return "renaming";
            32'd5:   return "in-order commit";
            32'd6:   return "x0 and illegal words";
            default: return "unknown group";
        endcase
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("mismatch at %0t: vector %0d %s is %h, expected %h",
                     $time, line_no, what, got, exp);
            errors++;
            group_errors++;
        end
    endtask

    task automatic report_group(input logic [31:0] grp);
        $display("test %0d (%s) done, %0d errors", grp, group_name(grp), group_errors);
        group_errors = 0;
    endtask

    task automatic drive_inputs();
        rdy         = (field(1) != 0);
        clr         = (field(2) != 0);
        inst_valid  = (field(3) != 0);
        inst_word   = field(4);
        pc          = field(5);
        commit_en   = (field(6) != 0);
        commit_data = field(7);
    endtask

    task automatic compare_outputs(input logic stall_seen);
        logic [31:0] exp_pc;
        exp_pc = (field(9) != 0) ? field(5) : 32'd0;  // pc of an accepted line, else zero.
        check_value("stall", 32'(stall_seen), field(8));
        check_value("disp_en", 32'(disp_en), field(9));
        check_value("disp_op", 32'(disp_op), field(10));
        check_value("disp_rd", 32'(disp_rd), field(11));
        check_value("disp_imm", disp_imm, field(12));
        check_value("disp_pc", disp_pc, exp_pc);
        check_value("disp_tag", 32'(disp_tag), field(13));
        check_value("rs1_val", rs1_val, field(14));
        check_value("rs1_tag", 32'(rs1_tag), field(15));
        check_value("rs2_val", rs2_val, field(16));
        check_value("rs2_tag", 32'(rs2_tag), field(17));
    endtask

    //////////////////////////////////////////////////
    // vector run
    //////////////////////////////////////////////////

    initial begin
        logic [31:0] cur_group;
        logic        stall_seen;
        logic        loaded;
        int          settle;

        rst         = 1'b1;
        rdy         = 1'b0;
        clr         = 1'b0;
        inst_valid  = 1'b0;
        inst_word   = '0;
        pc          = '0;
        commit_en   = 1'b0;
        commit_data = '0;
        errors       = 0;
        checks       = 0;
        group_errors = 0;
        line_no      = 0;

        $readmemh("verif/rename_vectors.txt", vec_mem);
        loaded = !((vec_mem[0] === 'x) || (vec_mem[0] == 32'd0));
        if (!loaded) begin
            $display("vector file verif/rename_vectors.txt could not be read");
            errors++;
        end

        repeat (2) @(posedge clk);  // two reset cycles.
        @(negedge clk);
        rst = 1'b0;

        settle = 0;
        while (((disp_en !== 1'b0) || (stall !== 1'b0)) && (settle < SETTLE_MAX)) begin
            @(posedge clk);
            settle++;
        end
        if (settle >= SETTLE_MAX) begin
            $display("disp_en or stall still high %0d cycles after reset", SETTLE_MAX);
            errors++;
        end

        cur_group = vec_mem[0];
        while (loaded && (line_no < MAX_LINES) && (field(0) !== END_MARK)) begin
            if (field(0) !== cur_group) begin
                report_group(cur_group);
                cur_group = field(0);
            end
            @(negedge clk);
            drive_inputs();
            #(HALF_CLK / 2);
            stall_seen = stall;  // level seen while this line is applied.
            @(posedge clk);
            #1;
            compare_outputs(stall_seen);
            line_no++;
        end
        if (loaded) begin
            report_group(cur_group);
        end
        if (line_no >= MAX_LINES) begin
            $display("vector file has no end marker within %0d lines", MAX_LINES);
            errors++;
        end

        @(negedge clk);
        inst_valid = 1'b0;
        commit_en  = 1'b0;

        $display("%0d vectors, %0d checks, %0d errors", line_no, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: verif/rename_vectors.txt
// grp rdy clr valid inst pc commit_en commit_data | stall disp_en op rd imm tag
// rs1_val rs1_tag rs2_val rs2_tag; stall is the level while the line is applied.
// group 1, one instruction of each class.
01 1 0 1 123452b7 00001000 0 00000000 0 1 7 05 12345000 1 00000000 0 00000000 0
01 1 0 1 fffff317 00001004 0 00000000 0 1 8 06 fffff000 2 00000000 0 00000000 0
01 1 0 1 ff9ff0ef 00001008 0 00000000 0 1 5 01 fffffff8 3 00000000 0 00000000 0
01 1 0 1 ff000167 0000100c 0 00000000 0 1 6 02 fffffff0 4 00000000 0 00000000 0
01 1 0 1 7ff02183 00001010 0 00000000 0 1 2 03 000007ff 5 00000000 0 00000000 0
01 1 0 1 fff00213 00001014 0 00000000 0 1 1 04 ffffffff 6 00000000 0 00000000 0
01 1 0 1 000003b3 00001018 0 00000000 0 1 0 07 00000000 7 00000000 0 00000000 0
01 1 0 1 fe002e23 0000101c 0 00000000 0 1 3 00 fffffffc 0 00000000 0 00000000 0
01 1 0 1 fe0000e3 00001020 0 00000000 0 1 4 00 ffffffe0 0 00000000 0 00000000 0
01 1 0 1 00500413 00001024 0 00000000 0 1 1 08 00000005 8 00000000 0 00000000 0
// group 2, rob full, one commit frees a slot, tag wraps to 1.
02 1 0 1 00900493 00001028 0 00000000 1 0 0 00 00000000 0 00000000 0 00000000 0
02 1 0 1 00900493 00001028 1 00000064 1 0 0 00 00000000 0 00000000 0 00000000 0
02 1 0 1 00900493 00001028 1 00000200 0 1 1 09 00000009 1 00000000 0 00000000 0
// group 3, clr with a commit, then an instruction with rdy low.
03 1 1 1 00a00513 0000102c 1 00000300 0 0 0 00 00000000 0 00000000 0 00000000 0
03 1 0 1 00508463 00001030 0 00000000 0 1 4 00 00000008 0 00000300 0 00000064 0
03 0 0 1 123452b7 00001034 0 00000000 0 0 0 00 00000000 0 00000000 0 00000000 0
03 1 0 1 00628463 00001038 0 00000000 0 1 4 00 00000008 0 00000064 0 00000200 0
// group 4, two writers of x5 then a reader.
04 1 0 1 00100293 0000103c 0 00000000 0 1 1 05 00000001 1 00000000 0 00000000 0
04 1 0 1 00200293 00001040 0 00000000 0 1 1 05 00000002 2 00000000 0 00000000 0
04 1 0 1 00028463 00001044 0 00000000 0 1 4 00 00000008 0 00000064 2 00000000 0
// group 5, stale commit is dropped, current one lands.
05 1 0 0 00000000 00001048 1 00000011 0 0 0 00 00000000 0 00000000 0 00000000 0
05 1 0 1 00028463 0000104c 0 00000000 0 1 4 00 00000008 0 00000064 2 00000000 0
05 1 0 0 00000000 00001050 1 00000022 0 0 0 00 00000000 0 00000000 0 00000000 0
05 1 0 1 00028463 00001054 0 00000000 0 1 4 00 00000008 0 00000022 0 00000000 0
// group 6, x0 writer takes no tag, mul and fence are illegal.
06 1 0 1 00500013 00001058 0 00000000 0 1 1 00 00000005 0 00000000 0 00000000 0
06 1 0 1 00300613 0000105c 0 00000000 0 1 1 0c 00000003 3 00000000 0 00000000 0
06 1 0 1 022086b3 00001060 0 00000000 0 0 0 00 00000000 0 00000000 0 00000000 0
06 1 0 1 0000000f 00001064 0 00000000 0 0 0 00 00000000 0 00000000 0 00000000 0
// end marker.
ff 0 0 0 00000000 00000000 0 00000000 0 0 0 00 00000000 0 00000000 0 00000000 0
